//--- all.f
dac_tpl_pkg.sv
dac_pattern_if.sv
dac_sync_ctrl.sv
dac_pn_gen.sv
dac_xbar.sv
dac_channel.sv
dac_framer.sv
dac_tpl_core.sv
dac_tpl_props.sv
tb_dac_tpl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dac_tpl -f all.f -o Vtb_dac_tpl

./obj_dir/Vtb_dac_tpl +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
  exit 0
fi
exit 1

//--- tb_dac_tpl.sv
`timescale 1ns/1ps

module tb_dac_tpl;

  localparam int phase_cycles = 60;
  localparam int num_phases = 6;
  // Reset, sync waits and slack on top of the phases
  localparam int timeout_cycles = num_phases * phase_cycles + 140;

  logic clk = 1'b0;
  logic rst;
  logic link_ready;
  logic link_valid;
  logic [dac_tpl_pkg::link_w-1:0] link_data;
  logic [dac_tpl_pkg::num_channels-1:0] dac_valid;
  logic [dac_tpl_pkg::link_w-1:0] dma_data;
  logic dac_sync;
  logic ext_sync_arm;
  logic ext_sync_disarm;
  logic ext_sync_in;
  logic sync_status;
  logic [dac_tpl_pkg::num_channels*4-1:0] data_sel;
  logic [dac_tpl_pkg::num_channels*dac_tpl_pkg::sample_w-1:0] pat_data_0;
  logic [dac_tpl_pkg::num_channels*dac_tpl_pkg::sample_w-1:0] pat_data_1;
  logic [dac_tpl_pkg::num_channels-1:0] src_chan_sel;
  logic [dac_tpl_pkg::num_channels-1:0] enable;

  int assert_fails = 0;
  int cycles = 0;
  logic [31:0] lfsr = 32'h7f28;

  dac_tpl_core i_dut (.*);

  bind dac_tpl_core dac_tpl_props i_props (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, stimulus did not finish", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  // New DMA word every cycle, ready drops about one cycle in four with gaps
  task automatic run_cycles(input int n, input bit gaps);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      dma_data = rand_bits(64);
      link_ready = gaps ? (rand_bits(2) != 64'd0) : 1'b1;
    end
  endtask

  initial begin
    rst = 1'b1;
    link_ready = 1'b0;
    dma_data = '0;
    dac_sync = 1'b1;
    ext_sync_arm = 1'b0;
    ext_sync_disarm = 1'b0;
    ext_sync_in = 1'b0;
    data_sel = {dac_tpl_pkg::sel_dma, dac_tpl_pkg::sel_dma};
    pat_data_0 = '0;
    pat_data_1 = '0;
    src_chan_sel = 2'b10;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Identity crossbar, software sync released part way
    run_cycles(10, 1'b0);
    dac_sync = 1'b0;
    run_cycles(50, 1'b0);

    // Swapped crossbar, then channel 0 on the fixed pattern
    src_chan_sel = 2'b01;
    run_cycles(30, 1'b0);
    data_sel = {dac_tpl_pkg::sel_dma, dac_tpl_pkg::sel_pattern};
    pat_data_0 = 32'(rand_bits(32));
    pat_data_1 = 32'(rand_bits(32));
    run_cycles(30, 1'b0);

    // PN sources, restarted by a sync pulse
    data_sel = {dac_tpl_pkg::sel_pn15, dac_tpl_pkg::sel_pn7};
    run_cycles(25, 1'b0);
    dac_sync = 1'b1;
    run_cycles(5, 1'b0);
    dac_sync = 1'b0;
    run_cycles(25, 1'b0);
    data_sel = {dac_tpl_pkg::sel_pattern, 4'd7};
    run_cycles(5, 1'b0);

    // Back-pressure from random ready gaps
    data_sel = {dac_tpl_pkg::sel_dma, dac_tpl_pkg::sel_pn7};
    run_cycles(60, 1'b1);

    // **********************************************************************
    // External sync: arm, trigger, arm again, disarm
    // **********************************************************************
    data_sel = {dac_tpl_pkg::sel_dma, dac_tpl_pkg::sel_dma};
    ext_sync_arm = 1'b1;
    run_cycles(4, 1'b0);
    ext_sync_arm = 1'b0;
    run_cycles(10, 1'b0);
    ext_sync_in = 1'b1;
    run_cycles(2, 1'b0);
    ext_sync_in = 1'b0;
    run_cycles(10, 1'b0);
    ext_sync_arm = 1'b1;
    run_cycles(6, 1'b1);
    ext_sync_disarm = 1'b1;
    run_cycles(3, 1'b0);
    ext_sync_disarm = 1'b0;
    ext_sync_arm = 1'b0;
    run_cycles(20, 1'b0);

    // Arm and disarm edges in the same cycle, disarm has priority
    ext_sync_arm = 1'b1;
    ext_sync_disarm = 1'b1;
    run_cycles(3, 1'b0);
    ext_sync_arm = 1'b0;
    ext_sync_disarm = 1'b0;
    run_cycles(5, 1'b0);

    // Mixed sources under gaps
    src_chan_sel = 2'b10;
    pat_data_0 = 32'(rand_bits(32));
    pat_data_1 = 32'(rand_bits(32));
    data_sel = {dac_tpl_pkg::sel_pn15, dac_tpl_pkg::sel_pattern};
    run_cycles(40, 1'b1);
    run_cycles(4, 1'b0);

    $display("Assertion failures: %0d, cycles run: %0d", assert_fails, cycles);
    if (assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dac_tpl_props.sv
`timescale 1ns/1ps

module dac_tpl_props (
  input logic clk,
  input logic rst,
  input logic link_ready,
  input logic link_valid,
  input logic [dac_tpl_pkg::link_w-1:0] link_data,
  input logic [dac_tpl_pkg::num_channels-1:0] dac_valid,
  input logic [dac_tpl_pkg::link_w-1:0] dma_data,
  input logic dac_sync,
  input logic ext_sync_arm,
  input logic ext_sync_disarm,
  input logic ext_sync_in,
  input logic sync_status,
  input logic [dac_tpl_pkg::num_channels*4-1:0] data_sel,
  input logic [dac_tpl_pkg::num_channels*dac_tpl_pkg::sample_w-1:0] pat_data_0,
  input logic [dac_tpl_pkg::num_channels*dac_tpl_pkg::sample_w-1:0] pat_data_1,
  input logic [dac_tpl_pkg::num_channels-1:0] src_chan_sel,
  input logic [dac_tpl_pkg::num_channels-1:0] enable
);

  localparam int cw = dac_tpl_pkg::chan_w;
  localparam int sw = dac_tpl_pkg::sample_w;

  logic [dac_tpl_pkg::num_channels-1:0][cw-1:0] xbar_m;
  logic [dac_tpl_pkg::num_channels-1:0] enable_m;
  dac_tpl_pkg::link_beat_u chan_m;
  dac_tpl_pkg::link_beat_u framed;
  dac_tpl_pkg::link_beat_u link_m;
  logic [14:0] pn7_st;
  logic [14:0] pn15_st;
  logic [cw-1:0] pn7_w;
  logic [cw-1:0] pn15_w;
  logic arm_prev;
  logic disarm_prev;
  logic [2:0] sync_in_hist;
  logic armed_m;
  logic sync_m;

  // Bit-serial PN reference, returns the new state above the 32 output bits
  function automatic logic [14+cw:0] pn_run(input logic [14:0] st, input int len);
    logic [cw-1:0] w;
    logic b;
    w = '0;
    for (int i = 0; i < cw; i++) begin
      b = st[len-1] ^ st[len-2];
      st = {st[13:0], b};
      w = {w[cw-2:0], b};
    end
    return {st, w};
  endfunction

  assign sync_m = armed_m | dac_sync;

  // **********************************************************************
  // Shadow pipeline, one step per accepted link beat
  // **********************************************************************

  // Arm and disarm act one cycle after their edges, the sync input
  // three cycles after it rises
  always_ff @(posedge clk) begin
    if (rst) begin
      arm_prev <= 1'b0;
      disarm_prev <= 1'b0;
      sync_in_hist <= '0;
      armed_m <= 1'b0;
    end else begin
      arm_prev <= ext_sync_arm;
      disarm_prev <= ext_sync_disarm;
      sync_in_hist <= {sync_in_hist[1:0], ext_sync_in};
      if (ext_sync_disarm && !disarm_prev) begin
        armed_m <= 1'b0;
      end else if (ext_sync_arm && !arm_prev) begin
        armed_m <= 1'b1;
      end else if (sync_in_hist[1] && !sync_in_hist[2]) begin
        armed_m <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || sync_m) begin
      pn7_st <= '1;
      pn15_st <= '1;
      pn7_w <= dac_tpl_pkg::pn_seed;
      pn15_w <= dac_tpl_pkg::pn_seed;
    end else if (link_ready) begin
      {pn7_st, pn7_w} <= pn_run(pn7_st, 7);
      {pn15_st, pn15_w} <= pn_run(pn15_st, 15);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      xbar_m <= '0;
      chan_m <= '0;
      link_m <= '0;
    end else if (link_ready) begin
      for (int c = 0; c < dac_tpl_pkg::num_channels; c++) begin
        xbar_m[c] <= dma_data[cw*src_chan_sel[c] +: cw];
        if (sync_m) begin
          chan_m.samples[c] <= '0;
        end else begin
          case (data_sel[4*c +: 4])
            dac_tpl_pkg::sel_pattern: begin
              chan_m.samples[c][0] <= pat_data_0[sw*c +: sw];
              chan_m.samples[c][1] <= pat_data_1[sw*c +: sw];
            end
            dac_tpl_pkg::sel_dma: chan_m.samples[c] <= xbar_m[c];
            dac_tpl_pkg::sel_pn7: chan_m.samples[c] <= pn7_w;
            dac_tpl_pkg::sel_pn15: chan_m.samples[c] <= pn15_w;
            default: chan_m.samples[c] <= '0;
          endcase
        end
      end
      link_m <= framed;
    end
  end

  // Octets go out MSB first, so octet o is byte o counted from the top
  always_comb begin
    logic [cw-1:0] w;
    for (int l = 0; l < dac_tpl_pkg::num_lanes; l++) begin
      w = chan_m.samples[l];
      for (int o = 0; o < dac_tpl_pkg::octets_per_lane; o++) begin
        framed.octets[l][o] = w[cw-1-8*o -: 8];
      end
    end
    for (int c = 0; c < dac_tpl_pkg::num_channels; c++) begin
      enable_m[c] = (data_sel[4*c +: 4] == dac_tpl_pkg::sel_dma);
    end
  end

  // **********************************************************************
  // Checks
  // **********************************************************************

  a_reset: assert property (@(posedge clk) rst |=> !link_valid && link_data == '0)
    else begin
      $error("Link output was not cleared by reset");
      tb_dac_tpl.assert_fails++;
    end

  a_valid: assert property (@(posedge clk) !rst |=> link_valid)
    else begin
      $error("link_valid is low after reset was released");
      tb_dac_tpl.assert_fails++;
    end

  a_dac_valid: assert property (@(posedge clk) disable iff (rst)
      dac_valid == {dac_tpl_pkg::num_channels{link_ready & ~sync_m}})
    else begin
      $error("[ERROR] %0t dac_valid expected %b got %b", $time,
        $sampled({dac_tpl_pkg::num_channels{link_ready & ~sync_m}}), $sampled(dac_valid));
      tb_dac_tpl.assert_fails++;
    end

  a_enable: assert property (@(posedge clk) disable iff (rst) enable == enable_m)
    else begin
      $error("[ERROR] %0t enable expected %b got %b", $time,
        $sampled(enable_m), $sampled(enable));
      tb_dac_tpl.assert_fails++;
    end

  a_link_data: assert property (@(posedge clk) disable iff (rst) link_data == link_m)
    else begin
      $error("[ERROR] %0t link_data expected %h got %h", $time,
        $sampled(link_m), $sampled(link_data));
      tb_dac_tpl.assert_fails++;
    end

  a_hold: assert property (@(posedge clk) disable iff (rst) !link_ready |=> $stable(link_data))
    else begin
      $error("link_data changed while link_ready was low");
      tb_dac_tpl.assert_fails++;
    end

  a_sync_status: assert property (@(posedge clk) disable iff (rst) sync_status == armed_m)
    else begin
      $error("[ERROR] %0t sync_status expected %b got %b", $time,
        $sampled(armed_m), $sampled(sync_status));
      tb_dac_tpl.assert_fails++;
    end

  a_arm: assert property (@(posedge clk) disable iff (rst)
      $rose(ext_sync_arm) && !$rose(ext_sync_disarm) |=> sync_status)
    else begin
      $error("Arm edge did not raise sync_status");
      tb_dac_tpl.assert_fails++;
    end

  a_disarm: assert property (@(posedge clk) disable iff (rst)
      $rose(ext_sync_disarm) |=> !sync_status)
    else begin
      $error("Disarm edge did not clear sync_status on the next cycle");
      tb_dac_tpl.assert_fails++;
    end

  a_sync_in: assert property (@(posedge clk) disable iff (rst)
      $rose(ext_sync_in) |-> ##3 !sync_status)
    else begin
      $error("External sync input did not clear sync_status within three cycles");
      tb_dac_tpl.assert_fails++;
    end

endmodule

//--- dac_tpl_core.sv
`timescale 1ns/1ps

module dac_tpl_core (
  input  logic clk,
  input  logic rst,

  // Link side
  input  logic link_ready,
  output logic link_valid,
  output logic [dac_tpl_pkg::link_w-1:0] link_data,

  // DMA side
  output logic [dac_tpl_pkg::num_channels-1:0] dac_valid,
  input  logic [dac_tpl_pkg::link_w-1:0] dma_data,

  // Sync control
  input  logic dac_sync,
  input  logic ext_sync_arm,
  input  logic ext_sync_disarm,
  input  logic ext_sync_in,
  output logic sync_status,

  // Channel configuration
  input  logic [dac_tpl_pkg::num_channels*4-1:0] data_sel,
  input  logic [dac_tpl_pkg::num_channels*dac_tpl_pkg::sample_w-1:0] pat_data_0,
  input  logic [dac_tpl_pkg::num_channels*dac_tpl_pkg::sample_w-1:0] pat_data_1,
  input  logic [dac_tpl_pkg::num_channels-1:0] src_chan_sel,
  output logic [dac_tpl_pkg::num_channels-1:0] enable
);

  localparam int cw = dac_tpl_pkg::chan_w;
  localparam int sw = dac_tpl_pkg::sample_w;

  logic [dac_tpl_pkg::link_w-1:0] xbar_data;
  logic [dac_tpl_pkg::link_w-1:0] dac_data;

  dac_pattern_if pat_if ();

  // The whole pipeline moves only when the link takes a beat
  assign pat_if.advance = link_ready;
  assign dac_valid = {dac_tpl_pkg::num_channels{~pat_if.sync & link_ready}};

  always_ff @(posedge clk) begin
    if (rst) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= 1'b1;
    end
  end

  // **********************************************************************
  // Sync, PN sources and DMA crossbar
  // **********************************************************************

  dac_sync_ctrl i_sync_ctrl (
    .clk (clk),
    .rst (rst),
    .ext_sync_arm (ext_sync_arm),
    .ext_sync_disarm (ext_sync_disarm),
    .ext_sync_in (ext_sync_in),
    .dac_sync (dac_sync),
    .sync_status (sync_status),
    .pat (pat_if)
  );

  dac_pn_gen i_pn_gen (
    .clk (clk),
    .rst (rst),
    .pat (pat_if)
  );

  dac_xbar i_xbar (
    .clk (clk),
    .rst (rst),
    .advance (pat_if.advance),
    .dma_data (dma_data),
    .src_chan_sel (src_chan_sel),
    .xbar_data (xbar_data)
  );

  for (genvar i = 0; i < dac_tpl_pkg::num_channels; i++) begin : g_channel
    dac_channel i_channel (
      .clk (clk),
      .rst (rst),
      .data_sel (data_sel[4*i +: 4]),
      .pat_data_0 (pat_data_0[sw*i +: sw]),
      .pat_data_1 (pat_data_1[sw*i +: sw]),
      .dma_data (xbar_data[cw*i +: cw]),
      .pat (pat_if),
      .sample_data (dac_data[cw*i +: cw]),
      .enable (enable[i])
    );
  end

  // Lane mapping and link register
  dac_framer i_framer (
    .clk (clk),
    .rst (rst),
    .advance (pat_if.advance),
    .dac_data (dac_data),
    .link_data (link_data)
  );

endmodule

//--- dac_framer.sv
`timescale 1ns/1ps

module dac_framer (
  input  logic clk,
  input  logic rst,
  input  logic advance,
  input  logic [dac_tpl_pkg::link_w-1:0] dac_data,
  output logic [dac_tpl_pkg::link_w-1:0] link_data
);

  dac_tpl_pkg::link_beat_u chan_beat;
  dac_tpl_pkg::link_beat_u lane_beat;

  assign chan_beat = dac_data;

  // Lane l carries channel l, sample MSB octet first on the wire
  always_comb begin
    for (int l = 0; l < dac_tpl_pkg::num_lanes; l++) begin
      for (int o = 0; o < dac_tpl_pkg::octets_per_lane; o++) begin
        lane_beat.octets[l][o] = chan_beat.samples[l][o / 2][15 - 8 * (o % 2) -: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      link_data <= '0;
    end else if (advance) begin
      link_data <= lane_beat;
    end
  end

endmodule

//--- dac_channel.sv
`timescale 1ns/1ps

module dac_channel (
  input  logic clk,
  input  logic rst,
  input  logic [3:0] data_sel,
  input  logic [dac_tpl_pkg::sample_w-1:0] pat_data_0,
  input  logic [dac_tpl_pkg::sample_w-1:0] pat_data_1,
  input  logic [dac_tpl_pkg::chan_w-1:0] dma_data,
  dac_pattern_if.chan pat,
  output logic [dac_tpl_pkg::chan_w-1:0] sample_data,
  output logic enable
);

  logic [dac_tpl_pkg::chan_w-1:0] source_data;

  // **********************************************************************
  // Source select
  // **********************************************************************

  always_comb begin
    case (data_sel)
      dac_tpl_pkg::sel_pattern: begin
        // Sample 0 is the upper half of the channel word
        source_data = {pat_data_0, pat_data_1};
      end
      dac_tpl_pkg::sel_dma: begin
        source_data = dma_data;
      end
      dac_tpl_pkg::sel_pn7: begin
        source_data = pat.pn7_data;
      end
      dac_tpl_pkg::sel_pn15: begin
        source_data = pat.pn15_data;
      end
      default: begin
        source_data = '0;
      end
    endcase
  end

  // Output register, muted while the datapath is in sync
  always_ff @(posedge clk) begin
    if (rst) begin
      sample_data <= '0;
    end else if (pat.advance) begin
      sample_data <= pat.sync ? '0 : source_data;
    end
  end

  assign enable = (data_sel == dac_tpl_pkg::sel_dma);

endmodule

//--- dac_xbar.sv
`timescale 1ns/1ps

module dac_xbar (
  input  logic clk,
  input  logic rst,
  input  logic advance,
  input  logic [dac_tpl_pkg::link_w-1:0] dma_data,
  input  logic [dac_tpl_pkg::num_channels-1:0] src_chan_sel,
  output logic [dac_tpl_pkg::link_w-1:0] xbar_data
);

  logic [dac_tpl_pkg::num_channels-1:0][dac_tpl_pkg::chan_w-1:0] dma_slice;
  logic [dac_tpl_pkg::num_channels-1:0][dac_tpl_pkg::chan_w-1:0] xbar_q;

  assign dma_slice = dma_data;

  // Each output channel takes the DMA stream named by its select bit
  always_ff @(posedge clk) begin
    if (rst) begin
      xbar_q <= '0;
    end else if (advance) begin
      for (int c = 0; c < dac_tpl_pkg::num_channels; c++) begin
        xbar_q[c] <= dma_slice[src_chan_sel[c]];
      end
    end
  end

  assign xbar_data = xbar_q;

endmodule

//--- dac_pn_gen.sv
`timescale 1ns/1ps

module dac_pn_gen (
  input  logic clk,
  input  logic rst,
  dac_pattern_if.gen pat
);

  logic [dac_tpl_pkg::chan_w-1:0] pn7_word;
  logic [dac_tpl_pkg::chan_w-1:0] pn15_word;

  // **********************************************************************
  // Sequence stepping
  // **********************************************************************

  // Runs one full word of a Fibonacci LFSR with taps at len and len-1.
  // The low len bits of the previous word hold the LFSR state, and after
  // a full word has been shifted in the new word is its own state again.
  function automatic logic [dac_tpl_pkg::chan_w-1:0] pn_step(
    input logic [dac_tpl_pkg::chan_w-1:0] word,
    input int unsigned len
  );
    logic [dac_tpl_pkg::chan_w-1:0] state;
    logic fb;
    state = word;
    for (int i = 0; i < dac_tpl_pkg::chan_w; i++) begin
      fb = state[len-1] ^ state[len-2];
      state = {state[dac_tpl_pkg::chan_w-2:0], fb};
    end
    // First generated bit ends up in bit 31, so the word is MSB first
    return state;
  endfunction

  always_ff @(posedge clk) begin
    if (rst || pat.sync) begin
      pn7_word <= dac_tpl_pkg::pn_seed;
      pn15_word <= dac_tpl_pkg::pn_seed;
    end else if (pat.advance) begin
      // x^7 + x^6 + 1
      pn7_word <= pn_step(pn7_word, 7);
      // x^15 + x^14 + 1
      pn15_word <= pn_step(pn15_word, 15);
    end
  end

  assign pat.pn7_data = pn7_word;
  assign pat.pn15_data = pn15_word;

endmodule

//--- dac_sync_ctrl.sv
`timescale 1ns/1ps

module dac_sync_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic ext_sync_arm,
  input  logic ext_sync_disarm,
  input  logic ext_sync_in,
  input  logic dac_sync,
  output logic sync_status,
  dac_pattern_if.ctl pat
);

  logic arm_d1;
  logic disarm_d1;
  logic sync_in_m1;
  logic sync_in_m2;
  logic sync_in_d3;
  logic armed;

  // Control edges come from the local clock domain
  always_ff @(posedge clk) begin
    if (rst) begin
      arm_d1 <= 1'b0;
      disarm_d1 <= 1'b0;
      sync_in_m1 <= 1'b0;
      sync_in_m2 <= 1'b0;
      sync_in_d3 <= 1'b0;
    end else begin
      arm_d1 <= ext_sync_arm;
      disarm_d1 <= ext_sync_disarm;
      sync_in_m1 <= ext_sync_in;
      sync_in_m2 <= sync_in_m1;
      sync_in_d3 <= sync_in_m2;
    end
  end

  // Disarm has priority, then arm, then the external trigger
  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= 1'b0;
    end else if (ext_sync_disarm && !disarm_d1) begin
      armed <= 1'b0;
    end else if (ext_sync_arm && !arm_d1) begin
      armed <= 1'b1;
    end else if (sync_in_m2 && !sync_in_d3) begin
      armed <= 1'b0;
    end
  end

  assign sync_status = armed;
  assign pat.sync = armed | dac_sync;

endmodule

//--- dac_pattern_if.sv
`timescale 1ns/1ps

interface dac_pattern_if;

  // Shared PN words, one channel width each
  logic [dac_tpl_pkg::chan_w-1:0] pn7_data;
  logic [dac_tpl_pkg::chan_w-1:0] pn15_data;

  // Merged software and external sync
  logic sync;

  // Pipeline step, follows link_ready
  logic advance;

  modport gen (output pn7_data, output pn15_data, input sync, input advance);

  modport ctl (output sync);

  modport chan (input pn7_data, input pn15_data, input sync, input advance);

endinterface

//--- dac_tpl_pkg.sv
package dac_tpl_pkg;

  // **********************************************************************
  // Link and sample geometry
  // **********************************************************************

  localparam int num_channels = 2;
  localparam int samples_per_beat = 2;
  localparam int sample_w = 16;
  localparam int num_lanes = 2;
  localparam int octets_per_lane = 4;

  // Bits each channel contributes to one beat
  localparam int chan_w = samples_per_beat * sample_w;
  localparam int link_w = num_lanes * octets_per_lane * 8;

  // **********************************************************************
  // Per-channel source select codes
  // **********************************************************************

  localparam logic [3:0] sel_pattern = 4'd0;
  localparam logic [3:0] sel_dma = 4'd1;
  localparam logic [3:0] sel_pn7 = 4'd2;
  localparam logic [3:0] sel_pn15 = 4'd3;

  // PN registers sit here while sync is held
  localparam logic [chan_w-1:0] pn_seed = '1;

  // One link beat, seen either as lane octets or as channel samples.
  // Octet 0 of a lane is in the lowest bits; sample 0 of a channel is
  // the most significant one, hence the ascending sample range.
  typedef union packed {
    logic [num_lanes-1:0][octets_per_lane-1:0][7:0] octets;
    logic [num_channels-1:0][0:samples_per_beat-1][sample_w-1:0] samples;
  } link_beat_u;

endpackage
